/* gfx_settings.svh */
`ifndef GFX_SETTINGS_SVH
`define GFX_SETTINGS_SVH

// visible raster
`define GFX_HOR_PXL 16
`define GFX_VER_PXL 8

// horizontal timing in pixel clocks
`define GFX_HSYNC 4
`define GFX_HBACK 3
`define GFX_HFRONT 2

// vertical timing in lines
`define GFX_VSYNC 2
`define GFX_VBACK 1
`define GFX_VFRONT 1

// frame buffer depth, four pixels per word
`define GFX_FB_WORDS 32

// offset register sits right above the frame buffer
`define GFX_CONFIG_ADDR 32

`endif

/* hdl/gfx_bus_pkg.sv */
`default_nettype none

`include "gfx_settings.svh"

package gfx_bus_pkg;

    typedef logic [31:0] word_t;

    // one enable per byte lane
    typedef logic [3:0] byte_mask_t;

    // host side word address, covers buffer and config register
    typedef logic [5:0] bus_addr_t;

    typedef logic [$clog2(`GFX_FB_WORDS)-1:0] fb_addr_t;

    typedef struct packed {
        logic       read;
        logic       write;
        bus_addr_t  address;
        byte_mask_t mask;
        word_t      data_wr;
    } bus_req_t;

endpackage

`default_nettype wire

/* hdl/gfx_video_pkg.sv */
`default_nettype none

package gfx_video_pkg;

    // packed 3-3-2 red green blue
    typedef logic [7:0] color_t;

    typedef logic [7:0] coord_t;

    // counts visible pixels over one frame
    typedef logic [7:0] pix_index_t;

    typedef struct packed {
        logic   hsync;
        logic   vsync;
        logic   de;
        color_t color;
    } video_t;

    typedef enum logic {
        PORT_IDLE,
        PORT_READ_WAIT
    } port_state_t;

endpackage

`default_nettype wire

/* hdl/gfx_ram_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "gfx_settings.svh"

module gfx_ram_bank (
    input  wire logic                 vga_clk,
    input  wire gfx_bus_pkg::fb_addr_t a_addr_i,
    input  wire logic                 a_we_i,
    input  wire logic [7:0]           a_wdata_i,
    output logic [7:0]                a_rdata_o,
    input  wire gfx_bus_pkg::fb_addr_t b_addr_i,
    output logic [7:0]                b_rdata_o
);

    import gfx_bus_pkg::*;

    logic [7:0] mem [0:`GFX_FB_WORDS-1];

    // port a, bus side read and write
    always_ff @(posedge vga_clk) begin
        if (a_we_i) begin
            mem[a_addr_i] <= a_wdata_i;
        end
        a_rdata_o <= mem[a_addr_i];
    end

    // port b, scan-out read only
    always_ff @(posedge vga_clk) begin
        b_rdata_o <= mem[b_addr_i];
    end

endmodule

`default_nettype wire

/* hdl/gfx_bus_port.sv */
`timescale 1ns/10ps
`default_nettype none

`include "gfx_settings.svh"

module gfx_bus_port (
    input  wire logic                  vga_clk,
    input  wire logic                  rst,
    input  wire gfx_bus_pkg::bus_req_t bus_req_i,
    output gfx_bus_pkg::word_t         data_rd_o,
    output logic                       stall_o,
    output gfx_bus_pkg::fb_addr_t      bank_addr_o,
    output gfx_bus_pkg::byte_mask_t    bank_we_o,
    output gfx_bus_pkg::word_t         bank_wdata_o,
    input  wire gfx_bus_pkg::word_t    bank_rdata_i,
    output gfx_bus_pkg::word_t         offset_o
);

    import gfx_bus_pkg::*;
    import gfx_video_pkg::*;

    port_state_t state;
    word_t       offset_q;
    word_t       rd_cfg_q;
    logic        rd_mem_q;

    logic is_config;
    logic is_mem;
    logic take_write;
    logic take_read;

    assign is_config = (bus_req_i.address == bus_addr_t'(`GFX_CONFIG_ADDR));
    assign is_mem = (bus_req_i.address < bus_addr_t'(`GFX_CONFIG_ADDR));

    // write wins over read when both strobes are up
    assign take_write = bus_req_i.write && !stall_o;
    assign take_read = bus_req_i.read && !bus_req_i.write && !stall_o;

    assign stall_o = (state == PORT_READ_WAIT);
    assign offset_o = offset_q;

    // bank word arrives the cycle after the stall
    assign data_rd_o = rd_mem_q ? bank_rdata_i : rd_cfg_q;

    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            state <= PORT_IDLE;
            bank_we_o <= '0;
            offset_q <= '0;
            rd_cfg_q <= '0;
            rd_mem_q <= 1'b0;
        end else begin
            bank_we_o <= '0;
            rd_cfg_q <= '0;
            rd_mem_q <= (state == PORT_READ_WAIT);
            case (state)
                PORT_IDLE: begin
                    if (take_write && is_mem) begin
                        bank_we_o <= bus_req_i.mask;
                    end else if (take_write && is_config) begin
                        offset_q <= bus_req_i.data_wr;
                    end else if (take_read && is_config) begin
                        rd_cfg_q <= offset_q;
                    end else if (take_read && is_mem) begin
                        state <= PORT_READ_WAIT;
                    end
                end
                PORT_READ_WAIT: begin
                    state <= PORT_IDLE;
                end
                default: begin
                    state <= PORT_IDLE;
                end
            endcase
        end
    end

    // address and data go to the banks one cycle after sampling
    always_ff @(posedge vga_clk) begin
        if (!stall_o) begin
            bank_addr_o <= fb_addr_t'(bus_req_i.address);
            bank_wdata_o <= bus_req_i.data_wr;
        end
    end

    // host must keep its strobes low while stalled
    assert property (@(posedge vga_clk) disable iff (rst)
        stall_o |-> !bus_req_i.read && !bus_req_i.write)
        else $error("bus request while stall_o is high");

endmodule

`default_nettype wire

/* hdl/gfx_scan_timing.sv */
`timescale 1ns/10ps
`default_nettype none

`include "gfx_settings.svh"

module gfx_scan_timing (
    input  wire logic                 vga_clk,
    input  wire logic                 rst,
    output logic                      hsync_o,
    output logic                      vsync_o,
    output logic                      de_o,
    output gfx_video_pkg::pix_index_t pix_index_o
);

    import gfx_video_pkg::*;

    localparam int H_BEGIN = `GFX_HSYNC + `GFX_HBACK;
    localparam int V_BEGIN = `GFX_VSYNC + `GFX_VBACK;
    localparam int H_TOTAL = H_BEGIN + `GFX_HOR_PXL + `GFX_HFRONT;
    localparam int V_TOTAL = V_BEGIN + `GFX_VER_PXL + `GFX_VFRONT;
    localparam int PIX_TOTAL = `GFX_HOR_PXL * `GFX_VER_PXL;

    coord_t x;
    coord_t y;

    // raster position
    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            x <= '0;
            y <= '0;
        end else begin
            if (x == coord_t'(H_TOTAL - 1)) begin
                x <= '0;
                if (y == coord_t'(V_TOTAL - 1)) begin
                    y <= '0;
                end else begin
                    y <= y + 1'b1;
                end
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // positive sync pulses at the start of line and frame
    assign hsync_o = (x < coord_t'(`GFX_HSYNC));
    assign vsync_o = (y < coord_t'(`GFX_VSYNC));

    assign de_o = (x >= coord_t'(H_BEGIN)) && (x < coord_t'(H_BEGIN + `GFX_HOR_PXL))
        && (y >= coord_t'(V_BEGIN)) && (y < coord_t'(V_BEGIN + `GFX_VER_PXL));

    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            pix_index_o <= '0;
        end else if (de_o) begin
            if (pix_index_o == pix_index_t'(PIX_TOTAL - 1)) begin
                pix_index_o <= '0;
            end else begin
                pix_index_o <= pix_index_o + 1'b1;
            end
        end
    end

    assert property (@(posedge vga_clk) disable iff (rst)
        de_o |-> !hsync_o && !vsync_o)
        else $error("de high during sync");

endmodule

`default_nettype wire

/* hdl/gfx_pixel_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

`include "gfx_settings.svh"

module gfx_pixel_fetch (
    input  wire logic                      vga_clk,
    input  wire logic                      rst,
    input  wire logic                      hsync_i,
    input  wire logic                      vsync_i,
    input  wire logic                      de_i,
    input  wire gfx_video_pkg::pix_index_t pix_index_i,
    input  wire gfx_bus_pkg::word_t        offset_i,
    output gfx_bus_pkg::fb_addr_t          fb_addr_o,
    input  wire gfx_bus_pkg::word_t        fb_data_i,
    output gfx_video_pkg::video_t          video_o
);

    import gfx_bus_pkg::*;
    import gfx_video_pkg::*;

    word_t      fetch_word;
    word_t      latched_q;
    logic [1:0] pix_lane;
    color_t     pix_color;

    assign pix_lane = pix_index_i[1:0];

    // one word ahead of the word being shown
    assign fetch_word = word_t'(pix_index_i >> 2) + (offset_i >> 2) + 1'b1;
    assign fb_addr_o = fb_addr_t'(fetch_word % `GFX_FB_WORDS);

    // the bank has returned the next word by the last pixel of a group
    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            latched_q <= '0;
        end else if (pix_lane == 2'd3) begin
            latched_q <= fb_data_i;
        end
    end

    // little endian, pixel 0 in the low byte
    assign pix_color = latched_q[pix_lane * $bits(color_t) +: $bits(color_t)];

    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            video_o.hsync <= 1'b1;
            video_o.vsync <= 1'b1;
            video_o.de <= 1'b0;
            video_o.color <= '0;
        end else begin
            video_o.hsync <= hsync_i;
            video_o.vsync <= vsync_i;
            video_o.de <= de_i;
            video_o.color <= de_i ? pix_color : '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/gfx_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module gfx_controller (
    input  wire logic                  vga_clk,
    input  wire logic                  rst,
    input  wire gfx_bus_pkg::bus_req_t bus_req_i,
    output gfx_bus_pkg::word_t         data_rd_o,
    output logic                       stall_o,
    output gfx_video_pkg::video_t      video_o
);

    import gfx_bus_pkg::*;
    import gfx_video_pkg::*;

    fb_addr_t   bank_addr;
    byte_mask_t bank_we;
    word_t      bank_wdata;
    word_t      bank_rdata;
    word_t      offset;

    fb_addr_t   fetch_addr;
    word_t      fetch_data;

    logic       hsync;
    logic       vsync;
    logic       de;
    pix_index_t pix_index;

    gfx_bus_port u_bus_port (
        .vga_clk      (vga_clk),
        .rst          (rst),
        .bus_req_i    (bus_req_i),
        .data_rd_o    (data_rd_o),
        .stall_o      (stall_o),
        .bank_addr_o  (bank_addr),
        .bank_we_o    (bank_we),
        .bank_wdata_o (bank_wdata),
        .bank_rdata_i (bank_rdata),
        .offset_o     (offset)
    );

    // one bank per byte lane
    for (genvar lane = 0; lane < 4; lane++) begin : g_bank
        gfx_ram_bank u_bank (
            .vga_clk   (vga_clk),
            .a_addr_i  (bank_addr),
            .a_we_i    (bank_we[lane]),
            .a_wdata_i (bank_wdata[8 * lane +: 8]),
            .a_rdata_o (bank_rdata[8 * lane +: 8]),
            .b_addr_i  (fetch_addr),
            .b_rdata_o (fetch_data[8 * lane +: 8])
        );
    end

    gfx_scan_timing u_scan_timing (
        .vga_clk     (vga_clk),
        .rst         (rst),
        .hsync_o     (hsync),
        .vsync_o     (vsync),
        .de_o        (de),
        .pix_index_o (pix_index)
    );

    gfx_pixel_fetch u_pixel_fetch (
        .vga_clk     (vga_clk),
        .rst         (rst),
        .hsync_i     (hsync),
        .vsync_i     (vsync),
        .de_i        (de),
        .pix_index_i (pix_index),
        .offset_i    (offset),
        .fb_addr_o   (fetch_addr),
        .fb_data_i   (fetch_data),
        .video_o     (video_o)
    );

endmodule

`default_nettype wire

/* bench/gfx_controller_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "gfx_settings.svh"

module gfx_controller_tb;

    import gfx_bus_pkg::*;
    import gfx_video_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int LINE_CYCLES = `GFX_HSYNC + `GFX_HBACK + `GFX_HOR_PXL + `GFX_HFRONT;
    localparam int FRAME_LINES = `GFX_VSYNC + `GFX_VBACK + `GFX_VER_PXL + `GFX_VFRONT;
    localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;
    localparam int FRAME_PIXELS = `GFX_HOR_PXL * `GFX_VER_PXL;
    localparam int RANDOM_OPS = 40;
    localparam int READ_TIMEOUT = 6;

    // cycle budget of each test
    localparam int RESET_BUDGET = 10;
    localparam int RW_BUDGET = 2 * `GFX_FB_WORDS + 8 * RANDOM_OPS;
    localparam int CONFIG_BUDGET = 10;
    localparam int RASTER_BUDGET = 3 * FRAME_CYCLES;
    localparam int PIXEL_BUDGET = 2 * 4 * FRAME_CYCLES;
    localparam int WATCHDOG_CYCLES = RESET_BUDGET + RW_BUDGET + CONFIG_BUDGET
        + RASTER_BUDGET + PIXEL_BUDGET + FRAME_CYCLES;

    logic     vga_clk;
    logic     rst;
    bus_req_t bus_req;
    word_t    data_rd;
    logic     stall;
    video_t   video;

    integer seed;
    int     error_count;
    int     tests_run;
    int     tests_failed;

    // frame buffer and offset as the host sees them
    word_t model [0:`GFX_FB_WORDS-1];
    word_t offset_model;

    logic  mem_rd_accept;
    logic  cfg_rd_accept;
    logic  rd_pipe0;
    logic  rd_pipe1;
    logic  cfg_pipe;
    word_t exp_rd;
    word_t exp_cfg;

    logic hs_q;
    logic vs_q;
    logic hsync_rise;
    logic vsync_rise;
    int   hs_low_cnt;
    int   de_cnt;
    int   vs_low_lines;
    int   de_lines;

    int     pix_cnt;
    int     pix_checked;
    logic   pix_check_en;
    color_t exp_color;

    gfx_controller DUT (
        .vga_clk   (vga_clk),
        .rst       (rst),
        .bus_req_i (bus_req),
        .data_rd_o (data_rd),
        .stall_o   (stall),
        .video_o   (video)
    );

    initial begin
        vga_clk = 1'b0;
        forever #(CLK_PERIOD / 2) vga_clk = ~vga_clk;
    end

    assign mem_rd_accept = bus_req.read && !bus_req.write && !stall
        && (bus_req.address < bus_addr_t'(`GFX_CONFIG_ADDR));
    assign cfg_rd_accept = bus_req.read && !bus_req.write && !stall
        && (bus_req.address == bus_addr_t'(`GFX_CONFIG_ADDR));

    always_ff @(posedge vga_clk) begin
        if (!rst && bus_req.write && !stall
            && (bus_req.address < bus_addr_t'(`GFX_CONFIG_ADDR))) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus_req.mask[lane]) begin
                    model[fb_addr_t'(bus_req.address)][8 * lane +: 8] <=
                        bus_req.data_wr[8 * lane +: 8];
                end
            end
        end
    end

    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            offset_model <= '0;
            rd_pipe0 <= 1'b0;
            rd_pipe1 <= 1'b0;
            cfg_pipe <= 1'b0;
            exp_rd <= '0;
            exp_cfg <= '0;
        end else begin
            rd_pipe0 <= mem_rd_accept;
            rd_pipe1 <= rd_pipe0;
            cfg_pipe <= cfg_rd_accept;
            if (mem_rd_accept) begin
                exp_rd <= model[fb_addr_t'(bus_req.address)];
            end
            if (cfg_rd_accept) begin
                exp_cfg <= offset_model;
            end
            if (bus_req.write && !stall
                && (bus_req.address == bus_addr_t'(`GFX_CONFIG_ADDR))) begin
                offset_model <= bus_req.data_wr;
            end
        end
    end

    assign hsync_rise = video.hsync && !hs_q;
    assign vsync_rise = video.vsync && !vs_q;

    // run lengths measured at the video output
    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            hs_q <= 1'b1;
            vs_q <= 1'b1;
            hs_low_cnt <= 0;
            de_cnt <= 0;
            vs_low_lines <= 0;
            de_lines <= 0;
            pix_cnt <= 0;
            pix_checked <= 0;
        end else begin
            hs_q <= video.hsync;
            vs_q <= video.vsync;
            hs_low_cnt <= video.hsync ? 0 : hs_low_cnt + 1;
            if (video.hsync) begin
                de_cnt <= 0;
            end else if (video.de) begin
                de_cnt <= de_cnt + 1;
            end
            if (hsync_rise) begin
                vs_low_lines <= video.vsync ? 0 : vs_low_lines + 1;
                if (vsync_rise) begin
                    de_lines <= 0;
                end else if (de_cnt == `GFX_HOR_PXL) begin
                    de_lines <= de_lines + 1;
                end
            end
            if (vsync_rise) begin
                pix_cnt <= 0;
            end else if (video.de) begin
                pix_cnt <= (pix_cnt + 1) % FRAME_PIXELS;
            end
            if (pix_check_en && video.de) begin
                pix_checked <= pix_checked + 1;
            end
        end
    end

    // byte p mod 4 of word (p/4 + offset/4) mod depth
    always_comb begin
        word_t      shown;
        fb_addr_t   widx;
        widx = fb_addr_t'(((pix_cnt / 4) + int'(offset_model >> 2)) % `GFX_FB_WORDS);
        shown = model[widx];
        exp_color = shown[8 * (pix_cnt % 4) +: 8];
    end

    reset_levels: assert property (@(posedge vga_clk)
        rst |-> !stall && !video.de && video.hsync && video.vsync)
        else begin
            error_count = error_count + 1;
            $display("[ERROR] %0t stall_o de hsync vsync got %b %b %b %b expected 0 0 1 1",
                $time, $sampled(stall), $sampled(video.de), $sampled(video.hsync),
                $sampled(video.vsync));
        end

    data_idle: assert property (@(posedge vga_clk)
        (!rd_pipe1 && !cfg_pipe) |-> data_rd == '0)
        else begin
            error_count = error_count + 1;
            $display("[ERROR] %0t data_rd_o got %h expected %h", $time,
                $sampled(data_rd), 32'h0);
        end

    mem_stall: assert property (@(posedge vga_clk) disable iff (rst)
        mem_rd_accept |=> stall ##1 !stall)
        else begin
            error_count = error_count + 1;
            $display("stall_o was not high for exactly one cycle after a read at %0t", $time);
        end

    mem_data: assert property (@(posedge vga_clk) disable iff (rst)
        rd_pipe1 |-> data_rd == exp_rd)
        else begin
            error_count = error_count + 1;
            $display("[ERROR] %0t data_rd_o got %h expected %h", $time,
                $sampled(data_rd), $sampled(exp_rd));
        end

    cfg_data: assert property (@(posedge vga_clk) disable iff (rst)
        cfg_pipe |-> !stall && data_rd == exp_cfg)
        else begin
            error_count = error_count + 1;
            $display("[ERROR] %0t data_rd_o got %h expected %h (stall_o %b)", $time,
                $sampled(data_rd), $sampled(exp_cfg), $sampled(stall));
        end

    hsync_low: assert property (@(posedge vga_clk) disable iff (rst)
        hsync_rise |-> hs_low_cnt == LINE_CYCLES - `GFX_HSYNC)
        else begin
            error_count = error_count + 1;
            $display("[ERROR] %0t hsync low cycles got %0d expected %0d", $time,
                $sampled(hs_low_cnt), LINE_CYCLES - `GFX_HSYNC);
        end

    de_per_line: assert property (@(posedge vga_clk) disable iff (rst)
        hsync_rise |-> (de_cnt == 0 || de_cnt == `GFX_HOR_PXL))
        else begin
            error_count = error_count + 1;
            $display("[ERROR] %0t de cycles per line got %0d expected %0d", $time,
                $sampled(de_cnt), `GFX_HOR_PXL);
        end

    vsync_low: assert property (@(posedge vga_clk) disable iff (rst)
        vsync_rise |-> vs_low_lines == FRAME_LINES - `GFX_VSYNC)
        else begin
            error_count = error_count + 1;
            $display("[ERROR] %0t vsync low lines got %0d expected %0d", $time,
                $sampled(vs_low_lines), FRAME_LINES - `GFX_VSYNC);
        end

    de_per_frame: assert property (@(posedge vga_clk) disable iff (rst)
        vsync_rise |-> de_lines == `GFX_VER_PXL)
        else begin
            error_count = error_count + 1;
            $display("[ERROR] %0t visible lines got %0d expected %0d", $time,
                $sampled(de_lines), `GFX_VER_PXL);
        end

    pixel_color: assert property (@(posedge vga_clk) disable iff (rst)
        (pix_check_en && video.de) |-> video.color == exp_color)
        else begin
            error_count = error_count + 1;
            $display("[ERROR] %0t video_o.color got %h expected %h at pixel %0d", $time,
                $sampled(video.color), $sampled(exp_color), $sampled(pix_cnt));
        end

    task automatic bus_write(input bus_addr_t addr, input byte_mask_t mask, input word_t data);
        @(posedge vga_clk);
        bus_req <= '{read: 1'b0, write: 1'b1, address: addr, mask: mask, data_wr: data};
        @(posedge vga_clk);
        bus_req <= '0;
    endtask

    task automatic bus_read(input bus_addr_t addr);
        int wait_cycles;
        wait_cycles = 0;
        @(posedge vga_clk);
        bus_req <= '{read: 1'b1, write: 1'b0, address: addr, mask: '0, data_wr: '0};
        @(posedge vga_clk);
        bus_req <= '0;
        do begin
            @(negedge vga_clk);
            wait_cycles++;
        end while (!(rd_pipe1 || cfg_pipe) && wait_cycles < READ_TIMEOUT);
        if (!(rd_pipe1 || cfg_pipe)) begin
            error_count = error_count + 1;
            $display("read of address %0d got no response within %0d cycles", addr,
                READ_TIMEOUT);
        end
        @(posedge vga_clk);
    endtask

    task automatic wait_frame_start();
        int wait_cycles;
        wait_cycles = 0;
        do begin
            @(negedge vga_clk);
            wait_cycles++;
        end while (!vsync_rise && wait_cycles < 2 * FRAME_CYCLES);
        if (!vsync_rise) begin
            error_count = error_count + 1;
            $display("no vsync pulse seen within %0d cycles", 2 * FRAME_CYCLES);
        end
        @(posedge vga_clk);
    endtask

    task automatic check_frame_with_offset(input word_t offset);
        int checked_before;
        bus_write(bus_addr_t'(`GFX_CONFIG_ADDR), 4'hf, offset);
        wait_frame_start();
        wait_frame_start();
        checked_before = pix_checked;
        pix_check_en <= 1'b1;
        wait_frame_start();
        pix_check_en <= 1'b0;
        @(posedge vga_clk);
        if (pix_checked - checked_before != FRAME_PIXELS) begin
            error_count = error_count + 1;
            $display("only %0d pixels compared in a frame with offset %0d",
                pix_checked - checked_before, offset);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        @(posedge vga_clk);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    initial begin
        int        mark;
        word_t     value;
        bus_addr_t addr;
        seed = 32'h791d2903;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        pix_check_en = 1'b0;
        rst = 1'b1;
        bus_req = '0;

        mark = error_count;
        repeat (3) @(posedge vga_clk);
        rst <= 1'b0;
        report_test("reset state", mark);

        mark = error_count;
        for (int i = 0; i < `GFX_FB_WORDS; i++) begin
            bus_write(bus_addr_t'(i), 4'hf, word_t'($random(seed)));
        end
        for (int i = 0; i < RANDOM_OPS; i++) begin
            value = word_t'($random(seed));
            addr = bus_addr_t'(value[4:0]);
            bus_write(addr, value[8:5], word_t'($random(seed)));
            bus_read(addr);
            value = word_t'($random(seed));
            bus_read(bus_addr_t'(value[4:0]));
        end
        report_test("masked writes and reads", mark);

        mark = error_count;
        bus_write(bus_addr_t'(`GFX_CONFIG_ADDR), 4'hf, word_t'($random(seed)));
        bus_read(bus_addr_t'(`GFX_CONFIG_ADDR));
        report_test("config register", mark);

        // three frames reach every raster monitor
        mark = error_count;
        wait_frame_start();
        wait_frame_start();
        wait_frame_start();
        report_test("raster timing", mark);

        mark = error_count;
        check_frame_with_offset(32'h0);
        // 37 words wraps past the end of the buffer
        check_frame_with_offset(32'h94);
        report_test("pixel content with offset", mark);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
            error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge vga_clk);
        $display("simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* gfx_controller.f */
+incdir+.
hdl/gfx_bus_pkg.sv
hdl/gfx_video_pkg.sv
hdl/gfx_ram_bank.sv
hdl/gfx_bus_port.sv
hdl/gfx_scan_timing.sv
hdl/gfx_pixel_fetch.sv
hdl/gfx_controller.sv
bench/gfx_controller_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= gfx_controller_tb
FILELIST  ?= gfx_controller.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
